//--- capture_config.svh
`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// One captured byte
`define CAP_DATA_WIDTH 8

// 64-entry buffer and the width of command arguments
`define CAP_ADDR_WIDTH 6

`endif

//--- capture_pkg.sv
`default_nettype none

`include "capture_config.svh"

package capture_pkg;

    // Host opcodes
    typedef enum logic [1:0] {
        CMD_NOP,
        CMD_ARM,   // Arg is frame length minus one
        CMD_ABORT,
        CMD_READ   // Arg is buffer address
    } cmd_op_t;

    typedef enum logic {
        ST_IDLE,
        ST_CAPTURE
    } eng_state_t;

    // Configuration block to engine
    typedef struct packed {
        logic                       arm;        // Single-cycle start
        logic                       abort;      // Single-cycle stop
        logic [`CAP_ADDR_WIDTH-1:0] frame_last; // Last byte address
    } cap_ctrl_t;

    // Engine to RAM port 0
    typedef struct packed {
        logic                       en;
        logic [`CAP_ADDR_WIDTH-1:0] addr;
        logic [`CAP_DATA_WIDTH-1:0] data;
    } wr_req_t;

endpackage

`default_nettype wire

//--- util_primitives.sv
`default_nettype none
`timescale 1ns/1ps

module register #(
    parameter WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic [WIDTH-1:0] next_value,
    output logic [WIDTH-1:0] value
);

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
        end else if (enable) begin
            value <= next_value;
        end
    end

endmodule

module counter #(
    parameter WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic             clear,
    output logic [WIDTH-1:0] value,
    output logic [WIDTH-1:0] next_value,
    input  logic             load_enable,
    input  logic [WIDTH-1:0] load_value,
    input  logic [WIDTH-1:0] max,
    output logic             complete
);

    register #(
        .WIDTH(WIDTH)
    ) count_reg (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable || clear || load_enable),
        .next_value(next_value),
        .value     (value)
    );

    always_comb begin
        complete = (value == max) && enable; // Step that lands on max
        if (load_enable) begin
            next_value = load_value;
        end else if (complete || clear) begin
            next_value = '0;                 // Wrap or restart
        end else begin
            next_value = value + 1'b1;
        end
    end

endmodule

module shift_register #(
    parameter             WIDTH = 8,
    parameter [WIDTH-1:0] RESET = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    output logic [WIDTH-1:0] value,
    output logic [WIDTH-1:0] next_value,
    input  logic             shift_in,
    output logic             shift_out,
    input  logic             load_enable,
    input  logic [WIDTH-1:0] load_value
);

    // Load beats shift
    always_comb begin
        if (load_enable) begin
            next_value = load_value;
        end else if (enable) begin
            next_value = {value[WIDTH-2:0], shift_in}; // MSB first
        end else begin
            next_value = value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= RESET;
        end else begin
            value <= next_value;
        end
    end

    assign shift_out = value[WIDTH-1];

endmodule

module memory_double_port #(
    parameter DATA_WIDTH = 32,
    parameter ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable0,
    input  logic                  write_enable0,
    input  logic [ADDR_WIDTH-1:0] addr_in0,
    input  logic [DATA_WIDTH-1:0] data_in0,
    output logic [DATA_WIDTH-1:0] data_out0,
    input  logic                  enable1,
    input  logic                  write_enable1,
    input  logic [ADDR_WIDTH-1:0] addr_in1,
    input  logic [DATA_WIDTH-1:0] data_in1,
    output logic [DATA_WIDTH-1:0] data_out1
);

    localparam DEPTH = 2**ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // One block per port keeps this a true dual-port block RAM;
    // a shared block would imply a write priority between the ports
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out0 <= '0;              // Output latch reset only
        end else if (enable0) begin
            if (write_enable0) begin
                mem[addr_in0] <= data_in0;
            end
            data_out0 <= mem[addr_in0];   // Read-first
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_out1 <= '0;
        end else if (enable1) begin
            if (write_enable1) begin
                mem[addr_in1] <= data_in1;
            end
            data_out1 <= mem[addr_in1];
        end
    end

endmodule

`default_nettype wire

//--- capture_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "capture_config.svh"

module capture_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  capture_pkg::cmd_op_t       cmd_op,
    input  logic [`CAP_ADDR_WIDTH-1:0] cmd_arg,
    output capture_pkg::cap_ctrl_t     ctrl,
    output logic                       rd_en,
    output logic [`CAP_ADDR_WIDTH-1:0] rd_addr,
    output logic                       rd_valid
);

    logic                       arm_cmd;
    logic                       abort_cmd;
    logic                       read_cmd;
    logic                       arm_q;
    logic                       abort_q;
    logic [`CAP_ADDR_WIDTH-1:0] frame_last;

    assign arm_cmd   = cmd_valid && (cmd_op == capture_pkg::CMD_ARM);
    assign abort_cmd = cmd_valid && (cmd_op == capture_pkg::CMD_ABORT);
    assign read_cmd  = cmd_valid && (cmd_op == capture_pkg::CMD_READ);

    // Frame length held until the next ARM
    register #(
        .WIDTH(`CAP_ADDR_WIDTH)
    ) frame_last_reg (
        .clk       (clk),
        .rst       (rst),
        .enable    (arm_cmd),
        .next_value(cmd_arg),
        .value     (frame_last)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            arm_q    <= 1'b0;
            abort_q  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            arm_q    <= arm_cmd;
            abort_q  <= abort_cmd;
            rd_valid <= read_cmd;   // RAM data lands one cycle later
        end
    end

    assign ctrl.arm        = arm_q;
    assign ctrl.abort      = abort_q;
    assign ctrl.frame_last = frame_last;

    // Read port driven straight from the command
    assign rd_en   = read_cmd;
    assign rd_addr = cmd_arg;

endmodule

`default_nettype wire

//--- capture_engine.sv
`default_nettype none
`timescale 1ns/1ps

`include "capture_config.svh"

module capture_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  capture_pkg::cap_ctrl_t ctrl,
    input  logic                   bit_valid,
    input  logic                   bit_in,
    output capture_pkg::wr_req_t   wr,
    output logic                   capturing,
    output logic                   done
);

    localparam BIT_W = $clog2(`CAP_DATA_WIDTH);

    capture_pkg::eng_state_t state;

    logic                       take_bit;
    logic                       byte_full;
    logic                       frame_full;
    logic                       frame_end;
    logic [`CAP_ADDR_WIDTH-1:0] byte_addr;
    logic [`CAP_DATA_WIDTH-1:0] shift_next;

    assign capturing = (state == capture_pkg::ST_CAPTURE);

    // A bit arriving with a restart is dropped along with the old frame
    assign take_bit  = bit_valid && capturing && !ctrl.arm;
    assign frame_end = frame_full && !ctrl.abort;

    shift_register #(
        .WIDTH(`CAP_DATA_WIDTH)
    ) deser (
        .clk        (clk),
        .rst        (rst),
        .enable     (take_bit),
        .value      (),
        .next_value (shift_next),
        .shift_in   (bit_in),
        .shift_out  (),
        .load_enable(ctrl.arm),
        .load_value ('0)
    );

    counter #(
        .WIDTH(BIT_W)
    ) bit_counter (
        .clk        (clk),
        .rst        (rst),
        .enable     (take_bit),
        .clear      (ctrl.arm),
        .value      (),
        .next_value (),
        .load_enable(1'b0),
        .load_value ('0),
        .max        (BIT_W'(`CAP_DATA_WIDTH - 1)),
        .complete   (byte_full)
    );

    counter #(
        .WIDTH(`CAP_ADDR_WIDTH)
    ) byte_counter (
        .clk        (clk),
        .rst        (rst),
        .enable     (wr.en),
        .clear      (ctrl.arm),
        .value      (byte_addr),
        .next_value (),
        .load_enable(1'b0),
        .load_value ('0),
        .max        (ctrl.frame_last),
        .complete   (frame_full)
    );

    // Byte goes out on the edge that takes its eighth bit
    assign wr.en   = byte_full;
    assign wr.addr = byte_addr;
    assign wr.data = shift_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= capture_pkg::ST_IDLE;
            done  <= 1'b0;
        end else begin
            done <= frame_end;
            if (ctrl.arm) begin
                state <= capture_pkg::ST_CAPTURE;   // Also restarts a running frame
            end else if (ctrl.abort || frame_end) begin
                state <= capture_pkg::ST_IDLE;
            end
        end
    end

endmodule

`default_nettype wire

//--- capture_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "capture_config.svh"

module capture_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  capture_pkg::cmd_op_t       cmd_op,
    input  logic [`CAP_ADDR_WIDTH-1:0] cmd_arg,
    input  logic                       bit_valid,
    input  logic                       bit_in,
    output logic                       rd_valid,
    output logic [`CAP_DATA_WIDTH-1:0] rd_data,
    output logic                       capturing,
    output logic                       done
);

    capture_pkg::cap_ctrl_t     ctrl;
    capture_pkg::wr_req_t       wr;
    logic                       rd_en;
    logic [`CAP_ADDR_WIDTH-1:0] rd_addr;

    capture_regs regs (
        .clk      (clk),
        .rst      (rst),
        .cmd_valid(cmd_valid),
        .cmd_op   (cmd_op),
        .cmd_arg  (cmd_arg),
        .ctrl     (ctrl),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid)
    );

    capture_engine engine (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .bit_valid(bit_valid),
        .bit_in   (bit_in),
        .wr       (wr),
        .capturing(capturing),
        .done     (done)
    );

    // Port 0 write only, port 1 read only
    memory_double_port #(
        .DATA_WIDTH(`CAP_DATA_WIDTH),
        .ADDR_WIDTH(`CAP_ADDR_WIDTH)
    ) buffer (
        .clk          (clk),
        .rst          (rst),
        .enable0      (wr.en),
        .write_enable0(wr.en),
        .addr_in0     (wr.addr),
        .data_in0     (wr.data),
        .data_out0    (),
        .enable1      (rd_en),
        .write_enable1(1'b0),
        .addr_in1     (rd_addr),
        .data_in1     ('0),
        .data_out1    (rd_data)
    );

endmodule

`default_nettype wire

//--- capture_props.sv
`default_nettype none
`timescale 1ns/1ps

module capture_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 capturing,
    input logic                 done,
    input logic                 wr_en,
    input logic                 cmd_valid,
    input capture_pkg::cmd_op_t cmd_op,
    input logic                 rd_valid
);

    int   failures = 0;   // Assertion failures so far
    logic read_cmd;

    assign read_cmd = cmd_valid && (cmd_op == capture_pkg::CMD_READ);

    done_not_capturing: assert property (@(posedge clk) disable iff (rst)
        done |-> !capturing)
        else begin
            failures++;
            $error("done is high while capturing is high");
        end

    write_in_capture: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> capturing)
        else begin
            failures++;
            $error("RAM write strobe outside a capture");
        end

    read_then_valid: assert property (@(posedge clk) disable iff (rst)
        read_cmd |=> rd_valid)
        else begin
            failures++;
            $error("rd_valid missing one cycle after a read command");
        end

    valid_after_read: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> $past(read_cmd))
        else begin
            failures++;
            $error("rd_valid without a read command one cycle before");
        end

endmodule

bind capture_top capture_props props (
    .clk      (clk),
    .rst      (rst),
    .capturing(capturing),
    .done     (done),
    .wr_en    (wr.en),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .rd_valid (rd_valid)
);

`default_nettype wire

//--- capture_checker.sv
`default_nettype none
`timescale 1ns/1ps

`include "capture_config.svh"

module capture_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  capture_pkg::cmd_op_t       cmd_op,
    input  logic [`CAP_ADDR_WIDTH-1:0] cmd_arg,
    input  logic                       bit_valid,
    input  logic                       bit_in,
    input  logic                       rd_valid,
    input  logic [`CAP_DATA_WIDTH-1:0] rd_data,
    input  logic                       capturing,
    input  logic                       done,
    output int                         error_count
);

    localparam int W     = `CAP_DATA_WIDTH;
    localparam int DEPTH = 2**`CAP_ADDR_WIDTH;

    logic [W-1:0]               model_mem [DEPTH];
    logic                       model_known [DEPTH];   // RAM is not reset
    logic [W-1:0]               model_shift;
    int                         model_bits;
    logic [`CAP_ADDR_WIDTH-1:0] model_addr;
    logic [`CAP_ADDR_WIDTH-1:0] model_last;
    logic                       model_cap;
    logic                       model_done;
    logic                       model_arm_q;
    logic                       model_abort_q;
    logic                       model_rd_valid;
    logic                       model_rd_known;
    logic [W-1:0]               model_rd_data;
    int                         errors = 0;

    assign error_count = errors;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH at %0t: %s expected 0x%0h actual 0x%0h",
                 $time, name, expected, actual);
        errors++;
    endtask

    // Model steps on the same edge as the DUT
    always @(posedge clk) begin : model_step
        logic         take;
        logic         frame_end;
        logic [W-1:0] next_shift;
        if (rst) begin
            model_shift    = '0;
            model_bits     = 0;
            model_addr     = '0;
            model_last     = '0;
            model_cap      = 1'b0;
            model_done     = 1'b0;
            model_arm_q    = 1'b0;
            model_abort_q  = 1'b0;
            model_rd_valid = 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                model_known[i] = 1'b0;
            end
        end else begin
            // Read-first so the read sees the contents before this edge
            model_rd_valid = cmd_valid && (cmd_op == capture_pkg::CMD_READ);
            if (model_rd_valid) begin
                model_rd_data  = model_mem[cmd_arg];
                model_rd_known = model_known[cmd_arg];
            end
            take      = bit_valid && model_cap && !model_arm_q;
            frame_end = 1'b0;
            if (model_arm_q) begin
                model_shift = '0;
                model_bits  = 0;
                model_addr  = '0;
            end else if (take) begin
                next_shift  = {model_shift[W-2:0], bit_in};   // MSB first
                model_shift = next_shift;
                if (model_bits == W - 1) begin
                    model_mem[model_addr]   = next_shift;
                    model_known[model_addr] = 1'b1;
                    frame_end  = (model_addr == model_last) && !model_abort_q;
                    model_addr = (model_addr == model_last) ? '0 : model_addr + 1'b1;
                    model_bits = 0;
                end else begin
                    model_bits++;
                end
            end
            model_done = frame_end;
            if (model_arm_q) begin
                model_cap = 1'b1;
            end else if (model_abort_q || frame_end) begin
                model_cap = 1'b0;
            end
            model_arm_q   = cmd_valid && (cmd_op == capture_pkg::CMD_ARM);
            model_abort_q = cmd_valid && (cmd_op == capture_pkg::CMD_ABORT);
            if (model_arm_q) begin
                model_last = cmd_arg;   // Frame length latched with the ARM
            end
        end
    end

    // Outputs compared mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (capturing !== model_cap) begin
                report_mismatch("capturing", 32'(model_cap), 32'(capturing));
            end
            if (done !== model_done) begin
                report_mismatch("done", 32'(model_done), 32'(done));
            end
            if (rd_valid !== model_rd_valid) begin
                report_mismatch("rd_valid", 32'(model_rd_valid), 32'(rd_valid));
            end else if (model_rd_valid && model_rd_known && rd_data !== model_rd_data) begin
                report_mismatch("rd_data", 32'(model_rd_data), 32'(rd_data));
            end
        end
    end

endmodule

`default_nettype wire

//--- capture_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "capture_config.svh"

module capture_tb;

    localparam int CLK_PERIOD = 20;
    localparam int A          = `CAP_ADDR_WIDTH;
    localparam int DEPTH      = 2**A;
    localparam int NUM_TESTS  = 6;
    localparam int MAX_GAP    = 3;
    // Longest frame at the widest gaps, plus commands and a full readback
    localparam int TEST_CYCLES     = DEPTH * `CAP_DATA_WIDTH * (MAX_GAP + 2) + 4 * DEPTH;
    localparam int WATCHDOG_CYCLES = 2 * NUM_TESTS * TEST_CYCLES;   // Test 6 runs two frames

    logic                       clk;
    logic                       rst;
    logic                       cmd_valid;
    capture_pkg::cmd_op_t       cmd_op;
    logic [A-1:0]               cmd_arg;
    logic                       bit_valid;
    logic                       bit_in;
    logic                       rd_valid;
    logic [`CAP_DATA_WIDTH-1:0] rd_data;
    logic                       capturing;
    logic                       done;
    int                         chk_errors;
    int                         tb_errors;
    int                         failed_tests;
    int                         test_num;
    int                         errors_at_start;
    integer                     seed;

    capture_top uut (.*);

    capture_checker chk (.error_count(chk_errors), .*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % n);
    endfunction

    function automatic int total_errors();
        return chk_errors + tb_errors + uut.props.failures;
    endfunction

    task automatic send_cmd(input capture_pkg::cmd_op_t op, input logic [A-1:0] arg);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_arg   = arg;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd_op    = capture_pkg::CMD_NOP;
    endtask

    // Random idle gaps between strobes
    task automatic send_bits(input int count);
        int sent;
        int gap;
        sent = 0;
        gap  = rand_below(MAX_GAP + 1);
        while (sent < count) begin
            @(negedge clk);
            if (gap > 0) begin
                bit_valid = 1'b0;
                gap--;
            end else begin
                bit_valid = 1'b1;
                bit_in    = 1'(rand_below(2));
                sent++;
                gap = rand_below(MAX_GAP + 1);
            end
        end
        @(negedge clk);
        bit_valid = 1'b0;
    endtask

    task automatic read_range(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            send_cmd(capture_pkg::CMD_READ, A'(first + i));
        end
        @(negedge clk);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < TEST_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("ERROR at %0t: no done pulse within %0d cycles", $time, TEST_CYCLES);
            tb_errors++;
        end else if (capturing !== 1'b0) begin
            $display("ERROR at %0t: capturing still high in the done cycle", $time);
            tb_errors++;
        end
        @(negedge clk);
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (capturing !== 1'b0 && cycles < 16) begin
            @(negedge clk);
            cycles++;
            if (done === 1'b1) begin
                $display("ERROR at %0t: done pulsed after an abort", $time);
                tb_errors++;
            end
        end
        if (capturing !== 1'b0) begin
            $display("ERROR at %0t: capturing did not drop after an abort", $time);
            tb_errors++;
        end
    endtask

    task automatic start_test();
        test_num++;
        errors_at_start = total_errors();
    endtask

    task automatic end_test(input string name);
        int delta;
        delta = total_errors() - errors_at_start;
        if (delta == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, delta);
            failed_tests++;
        end
    endtask

    initial begin
        int len;
        int short_len;
        int kept;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = capture_pkg::CMD_NOP;
        cmd_arg      = '0;
        bit_valid    = 1'b0;
        bit_in       = 1'b0;
        tb_errors    = 0;
        failed_tests = 0;
        test_num     = 0;
        seed         = 32'h645d_f1df;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test();
        read_range(0, 1);
        end_test("reset state");

        start_test();
        len = 1 + rand_below(DEPTH);
        send_bits(8);                        // Ignored before any ARM
        send_cmd(capture_pkg::CMD_ARM, A'(len - 1));
        send_bits(8 * len);
        wait_done();
        end_test("full frame capture");

        start_test();
        read_range(0, len);
        end_test("readback");

        start_test();
        send_bits(16);
        read_range(0, len);
        end_test("idle bits ignored");

        start_test();
        short_len = 2 + rand_below(DEPTH - 1);
        kept      = rand_below(short_len - 1);
        send_cmd(capture_pkg::CMD_ARM, A'(short_len - 1));
        send_bits(8 * kept + 1 + rand_below(7));   // Stops inside a byte
        send_cmd(capture_pkg::CMD_ABORT, '0);
        wait_idle();
        read_range(0, kept);
        send_cmd(capture_pkg::CMD_ARM, '0);
        send_bits(8);
        wait_done();
        read_range(0, 1);
        end_test("abort");

        start_test();
        send_cmd(capture_pkg::CMD_ARM, A'(DEPTH - 1));
        send_bits(8 * DEPTH);
        wait_done();
        short_len = 1 + rand_below(DEPTH / 2);
        send_cmd(capture_pkg::CMD_ARM, A'(short_len - 1));
        send_bits(8 * short_len);
        wait_done();
        read_range(0, DEPTH);
        end_test("rearm over an old frame");

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 test_num, failed_tests, total_errors());
        if (failed_tests == 0 && total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
capture_pkg.sv
util_primitives.sv
capture_regs.sv
capture_engine.sv
capture_top.sv
capture_props.sv
capture_checker.sv
capture_tb.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= capture_tb
FILELIST    ?= verilog.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= TEST RESULT: PASS
VFLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only --timing --assert
SIM_ARGS    ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_STRING)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
